// ==== spi_regmux.f ====
verilog/spi_regmux_pkg.sv
verilog/spi_sampler.sv
verilog/spi_frame_shifter.sv
verilog/reg_bank.sv
verilog/spi_router.sv
verilog/heartbeat_gray.sv
verilog/spi_regmux_top.sv
sim/spi_regmux_tb.sv

// ==== Makefile ====
TOP = spi_regmux_tb

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f spi_regmux.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== sim/spi_regmux_tb.sv ====
`timescale 1ns/1ps

module spi_regmux_tb;

  import spi_regmux_pkg::*;

  localparam int num_periph    = 3;
  localparam int tb_log2_delay = 4;
  // gray output must move at least this often
  localparam int hb_window     = 2 ** (tb_log2_delay + 1);
  // about 14 frames of 150 cycles, plus peripheral accesses and margin
  localparam int cycle_limit   = 4000;

  logic                  clk;
  logic                  reset;
  logic                  sclk;
  logic                  cs_n;
  logic                  mosi;
  logic                  special_n;
  logic [num_periph-1:0] miso_vec;
  logic                  miso;
  logic [num_periph-1:0] cs_vec_n;
  logic                  sclk_out;
  logic                  mosi_out;
  logic [1:0]            led;
  logic [1:0]            heartbeat;
  logic [2:0]            dac_ctrl;
  logic                  dac_rst;

  ctrl_regs_t            model;
  logic [15:0]           lfsr_state;
  logic [num_periph-1:0] exp_cs;
  logic                  exp_miso;
  logic [1:0]            hb_prev;
  int                    hb_stable;
  int                    cycles;
  int                    cs_errors;
  int                    miso_errors;
  int                    reg_errors;
  int                    hb_errors;
  int                    passthru_errors;

  spi_regmux_top #(
    .num_periph (num_periph),
    .log2_delay (tb_log2_delay)
  ) dut0 (
    .clk       (clk),
    .reset     (reset),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .special_n (special_n),
    .miso_vec  (miso_vec),
    .miso      (miso),
    .cs_vec_n  (cs_vec_n),
    .sclk_out  (sclk_out),
    .mosi_out  (mosi_out),
    .led       (led),
    .heartbeat (heartbeat),
    .dac_ctrl  (dac_ctrl),
    .dac_rst   (dac_rst)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////
  // expected pins from the model

  // select low only for a pass-through access to a muxed peripheral
  always_comb
  begin
    exp_miso = 1'b0;
    for (int i = 0; i < num_periph; i++)
    begin
      exp_cs[i] = !(special_n == 1'b1 && cs_n == 1'b0 && model.mux[i] == 1'b1);
      if (model.mux[i] && miso_vec[i])
        exp_miso = 1'b1;
    end
  end

  // heartbeat history, cycles since last change
  always @(posedge clk)
  begin
    if (reset)
    begin
      hb_prev   <= 2'b00;
      hb_stable <= 0;
    end
    else
    begin
      hb_prev   <= heartbeat;
      hb_stable <= (heartbeat != hb_prev) ? 0 : hb_stable + 1;
    end
  end

  ////////////////////////////////////////
  // continuous checks

  assert property (@(posedge clk) disable iff (reset) cs_vec_n == exp_cs)
    else
    begin
      cs_errors = cs_errors + 1;
      $display("[ERROR] cs_vec_n got %h expected %h", cs_vec_n, exp_cs);
    end

  // pass-through miso, or of the selected peripherals
  assert property (@(posedge clk) disable iff (reset) special_n |-> miso == exp_miso)
    else
    begin
      miso_errors = miso_errors + 1;
      $display("[ERROR] miso got %h expected %h", miso, exp_miso);
    end

  // sclk and mosi reach the peripherals unchanged
  assert property (@(posedge clk) disable iff (reset) sclk_out == sclk)
    else
    begin
      passthru_errors = passthru_errors + 1;
      $display("[ERROR] sclk_out got %h expected %h", sclk_out, sclk);
    end

  assert property (@(posedge clk) disable iff (reset) mosi_out == mosi)
    else
    begin
      passthru_errors = passthru_errors + 1;
      $display("[ERROR] mosi_out got %h expected %h", mosi_out, mosi);
    end

  assert property (@(posedge clk) disable iff (reset) $countones(heartbeat ^ hb_prev) <= 1)
    else
    begin
      hb_errors = hb_errors + 1;
      $display("heartbeat changed two bits at once, %h to %h", hb_prev, heartbeat);
    end

  assert property (@(posedge clk) disable iff (reset) hb_stable < hb_window)
    else
    begin
      hb_errors = hb_errors + 1;
      $display("heartbeat stopped moving for %0d cycles", hb_stable);
    end

  // run limit
  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles == cycle_limit)
    begin
      $display("timeout, run stopped after %0d cycles", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // stimulus helpers

  // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0])
      return (s >> 1) ^ 16'hb400;
    return s >> 1;
  endfunction

  // one lfsr step per bit taken
  task automatic take_bits(input int n, output logic [15:0] bits);
    bits = '0;
    for (int k = 0; k < n; k++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      bits = {bits[14:0], lfsr_state[0]};
    end
  endtask

  // register write as the bank should apply it
  function automatic ctrl_regs_t apply_write(input ctrl_regs_t r, input logic [7:0] addr,
                                             input logic [7:0] val);
    ctrl_regs_t n;
    n = r;
    if (addr == addr_mux)
      n.mux = val;
    else if (addr == addr_led)
    begin
      // low nibble sets, high nibble clears, clear wins
      for (int i = 0; i < 4; i++)
      begin
        if (val[i+4])
          n.led[i] = 1'b0;
        else if (val[i])
          n.led[i] = 1'b1;
      end
      // upper led bits can only be set
      for (int i = 4; i < 8; i++)
      begin
        if (val[i])
          n.led[i] = 1'b1;
      end
    end
    else if (addr == addr_dac)
      n.dac = val[2:0];
    else if (addr == addr_dac_rst)
      n.dac_rst = val[0];
    return n;
  endfunction

  // mode 0 frame with special_n low, miso read on each sclk rise
  task automatic reg_frame(input logic [7:0] addr, input logic [7:0] val, input int nbits);
    logic [15:0] word;
    logic [15:0] reply_exp;
    logic [15:0] reply_got;
    word      = {addr, val};
    reply_exp = {model.mux, model.led};
    reply_got = '0;
    @(negedge clk);
    special_n = 1'b0;
    @(negedge clk);
    cs_n = 1'b0;
    repeat (8) @(negedge clk);
    for (int i = 0; i < nbits; i++)
    begin
      mosi = word[15-i];
      repeat (4) @(negedge clk);
      reply_got[15-i] = miso;
      sclk = 1'b1;
      repeat (4) @(negedge clk);
      sclk = 1'b0;
    end
    repeat (4) @(negedge clk);
    cs_n = 1'b1;
    // bank updates 5 cycles after cs_n rises
    repeat (8) @(negedge clk);
    if (nbits == frame_bits)
    begin
      model = apply_write(model, addr, val);
      assert (reply_got == reply_exp)
        else
        begin
          miso_errors = miso_errors + 1;
          $display("[ERROR] miso readback got %h expected %h", reply_got, reply_exp);
        end
    end
    special_n = 1'b1;
  endtask

  // peripheral access, random miso from the peripherals
  task automatic periph_access(input int ncycles);
    logic [15:0] r;
    @(negedge clk);
    cs_n = 1'b0;
    repeat (ncycles)
    begin
      take_bits(num_periph, r);
      miso_vec = r[num_periph-1:0];
      @(negedge clk);
    end
    cs_n = 1'b1;
    @(negedge clk);
  endtask

  task automatic check_outputs();
    assert (led == model.led[1:0])
      else
      begin
        reg_errors = reg_errors + 1;
        $display("[ERROR] led got %h expected %h", led, model.led[1:0]);
      end
    assert (dac_ctrl == model.dac)
      else
      begin
        reg_errors = reg_errors + 1;
        $display("[ERROR] dac_ctrl got %h expected %h", dac_ctrl, model.dac);
      end
    assert (dac_rst == model.dac_rst)
      else
      begin
        reg_errors = reg_errors + 1;
        $display("[ERROR] dac_rst got %h expected %h", dac_rst, model.dac_rst);
      end
  endtask

  ////////////////////////////////////////
  // test sequence

  initial
  begin
    logic [15:0] r;
    reset           = 1'b1;
    sclk            = 1'b0;
    cs_n            = 1'b1;
    mosi            = 1'b0;
    special_n       = 1'b1;
    miso_vec        = '0;
    model           = '0;
    lfsr_state      = 16'd14493;
    cycles          = 0;
    cs_errors       = 0;
    miso_errors     = 0;
    reg_errors      = 0;
    hb_errors       = 0;
    passthru_errors = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // mux writes, then pass-through accesses
    repeat (3)
    begin
      take_bits(8, r);
      reg_frame(addr_mux, r[7:0], frame_bits);
      check_outputs();
      periph_access(6);
    end

    // led set and clear
    repeat (5)
    begin
      take_bits(8, r);
      reg_frame(addr_led, r[7:0], frame_bits);
      check_outputs();
    end

    // dac bits, then an address outside the map
    take_bits(8, r);
    reg_frame(addr_dac, r[7:0], frame_bits);
    check_outputs();
    take_bits(8, r);
    reg_frame(addr_dac_rst, r[7:0] | 8'h01, frame_bits);
    check_outputs();
    take_bits(7, r);
    reg_frame({1'b1, r[6:0]}, 8'hff, frame_bits);
    check_outputs();

    // short frame is dropped
    take_bits(8, r);
    reg_frame(addr_mux, r[7:0], 12);
    check_outputs();
    periph_access(6);

    // last mux value with every peripheral selected
    reg_frame(addr_mux, 8'h07, frame_bits);
    check_outputs();
    periph_access(10);

    repeat (4) @(negedge clk);
    $display("errors: cs %0d, miso %0d, regs %0d, heartbeat %0d, pass-through %0d",
             cs_errors, miso_errors, reg_errors, hb_errors, passthru_errors);
    if (cs_errors + miso_errors + reg_errors + hb_errors + passthru_errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== verilog/spi_regmux_top.sv ====
`timescale 1ns/1ps

module spi_regmux_top #(
  parameter int num_periph = 3,
  parameter int log2_delay = 20
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  sclk,
  input  logic                  cs_n,
  input  logic                  mosi,
  input  logic                  special_n,
  input  logic [num_periph-1:0] miso_vec,
  output logic                  miso,
  output logic [num_periph-1:0] cs_vec_n,
  output logic                  sclk_out,
  output logic                  mosi_out,
  output logic [1:0]            led,
  output logic [1:0]            heartbeat,
  output logic [2:0]            dac_ctrl,
  output logic                  dac_rst
);

  import spi_regmux_pkg::*;

  spi_sample_t sample;
  reg_frame_t  frame;
  logic        frame_valid;
  logic        reg_miso;
  ctrl_regs_t  regs;

  // sclk and mosi go straight to every peripheral
  assign sclk_out = sclk;
  assign mosi_out = mosi;

  // board leds on the low bits of the led register
  assign led      = regs.led[1:0];
  assign dac_ctrl = regs.dac;
  assign dac_rst  = regs.dac_rst;

  ////////////////////////////////////////
  // register frame path

  spi_sampler sampler0 (
    .clk       (clk),
    .reset     (reset),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .special_n (special_n),
    .sample    (sample)
  );

  spi_frame_shifter shifter0 (
    .clk         (clk),
    .reset       (reset),
    .sample      (sample),
    .regs        (regs),
    .frame       (frame),
    .frame_valid (frame_valid),
    .reg_miso    (reg_miso)
  );

  reg_bank bank0 (
    .clk         (clk),
    .reset       (reset),
    .frame       (frame),
    .frame_valid (frame_valid),
    .regs        (regs)
  );

  ////////////////////////////////////////
  // pin routing and heartbeat

  spi_router #(
    .num_periph (num_periph)
  ) router0 (
    .clk       (clk),
    .cs_n      (cs_n),
    .special_n (special_n),
    .regs      (regs),
    .reg_miso  (reg_miso),
    .miso_vec  (miso_vec),
    .cs_vec_n  (cs_vec_n),
    .miso      (miso)
  );

  heartbeat_gray #(
    .log2_delay (log2_delay)
  ) heartbeat0 (
    .clk   (clk),
    .reset (reset),
    .leds  (heartbeat)
  );

endmodule

// ==== verilog/heartbeat_gray.sv ====
`timescale 1ns/1ps

module heartbeat_gray #(
  parameter int log2_delay = 20
) (
  input  logic       clk,
  input  logic       reset,
  output logic [1:0] leds
);

  localparam int cnt_w = log2_delay + 2;

  logic [cnt_w-1:0] counter;
  logic [1:0]       top_bits;

  assign top_bits = counter[cnt_w-1 -: 2];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      counter <= '0;
      leds    <= '0;
    end
    else
    begin
      counter <= counter + 1'b1;
      // gray code, one led changes per step
      leds    <= top_bits ^ (top_bits >> 1);
    end
  end

endmodule

// ==== verilog/spi_router.sv ====
`timescale 1ns/1ps

module spi_router #(
  parameter int num_periph = 3
) (
  input  logic                       clk,
  input  logic                       cs_n,
  input  logic                       special_n,
  input  spi_regmux_pkg::ctrl_regs_t regs,
  input  logic                       reg_miso,
  input  logic [num_periph-1:0]      miso_vec,
  output logic [num_periph-1:0]      cs_vec_n,
  output logic                       miso
);

  import spi_regmux_pkg::*;

  logic [num_periph-1:0] sel;

  // peripherals picked by the mux register
  assign sel = regs.mux[num_periph-1:0];

  ////////////////////////////////////////
  // chip selects

  // special low: bank frame, keep every peripheral off the bus
  assign cs_vec_n = special_n ? ~(sel & {num_periph{~cs_n}}) : '1;

  ////////////////////////////////////////
  // miso

  // or of the selected peripherals, no tri-state on the board side
  assign miso = special_n ? |(sel & miso_vec) : reg_miso;

  // no spurious peripheral writes during bank frames
  assert property (@(posedge clk)
    !special_n |-> (cs_vec_n == '1))
    else $error("router: cs_vec_n %0h with special_n low", cs_vec_n);

endmodule

// ==== verilog/reg_bank.sv ====
`timescale 1ns/1ps

module reg_bank (
  input  logic                       clk,
  input  logic                       reset,
  input  spi_regmux_pkg::reg_frame_t frame,
  input  logic                       frame_valid,
  output spi_regmux_pkg::ctrl_regs_t regs
);

  import spi_regmux_pkg::*;

  logic [7:0] led_next;
  logic       addr_known;

  ////////////////////////////////////////
  // led set / clear

  // low nibble sets bits, high nibble clears them
  // clear wins over set for the same bit
  assign led_next = (regs.led | frame.val) & ~(frame.val >> 4);

  always_comb
  begin
    case (frame.addr)
      addr_mux,
      addr_led,
      addr_dac,
      addr_dac_rst: addr_known = 1'b1;
      default:      addr_known = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // address decode

  always_ff @(posedge clk)
  begin
    if (reset)
      regs <= '0;
    else if (frame_valid)
    begin
      case (frame.addr)
        addr_mux:
          regs.mux <= frame.val;
        addr_led:
          regs.led <= led_next;
        // three dac control lines
        addr_dac:
          regs.dac <= frame.val[2:0];
        // own register, toggles without touching dac bits
        addr_dac_rst:
          regs.dac_rst <= frame.val[0];
        default:
          regs <= regs;
      endcase
    end
  end

  // stray address from the mcu must not disturb anything
  assert property (@(posedge clk) disable iff (reset)
    (frame_valid && !addr_known) |=> $stable(regs))
    else $error("reg_bank: unknown addr %0h changed regs", $past(frame.addr));

endmodule

// ==== verilog/spi_frame_shifter.sv ====
`timescale 1ns/1ps

module spi_frame_shifter (
  input  logic                        clk,
  input  logic                        reset,
  input  spi_regmux_pkg::spi_sample_t sample,
  input  spi_regmux_pkg::ctrl_regs_t  regs,
  output spi_regmux_pkg::reg_frame_t  frame,
  output logic                        frame_valid,
  output logic                        reg_miso
);

  import spi_regmux_pkg::*;

  // room above frame_bits so long frames do not alias
  localparam int cnt_w = $clog2(frame_bits) + 1;

  logic [frame_bits-1:0] rx_sh;
  logic [frame_bits-1:0] reply_sh;
  logic [cnt_w-1:0]      bit_cnt;
  logic                  frame_open;
  reply_t                reply;

  assign reply.mux = regs.mux;
  assign reply.led = regs.led;

  ////////////////////////////////////////
  // frame control

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      frame_open  <= 1'b0;
      bit_cnt     <= '0;
      frame_valid <= 1'b0;
    end
    else
    begin
      // exact bit count or the frame is dropped
      frame_valid <= sample.frame_end & frame_open & (bit_cnt == cnt_w'(frame_bits));
      if (sample.frame_start)
      begin
        frame_open <= 1'b1;
        bit_cnt    <= '0;
      end
      else if (sample.frame_end)
        frame_open <= 1'b0;
      else if (frame_open && sample.special && sample.sclk_rise && !(&bit_cnt))
        // saturate, anything past frame_bits is invalid anyway
        bit_cnt <= bit_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////
  // data shifters

  // receive side, mosi into lsb
  always_ff @(posedge clk)
  begin
    if (frame_open && sample.special && sample.sclk_rise && !sample.frame_end)
      rx_sh <= {rx_sh[frame_bits-2:0], sample.mosi};
  end

  // reply side, first bit out right at frame start
  always_ff @(posedge clk)
  begin
    if (reset)
      reg_miso <= 1'b0;
    else if (sample.frame_start)
      reg_miso <= reply[frame_bits-1];
    else if (frame_open && sample.sclk_fall)
      reg_miso <= reply_sh[frame_bits-2];
  end

  always_ff @(posedge clk)
  begin
    if (sample.frame_start)
      reply_sh <= reply;
    else if (frame_open && sample.sclk_fall)
      // zero fill behind the reply
      reply_sh <= {reply_sh[frame_bits-2:0], 1'b0};
  end

  assign frame = reg_frame_t'(rx_sh);

  // count holds from frame end until the strobe
  assert property (@(posedge clk) disable iff (reset)
    frame_valid |-> (bit_cnt == cnt_w'(frame_bits)))
    else $error("shifter: frame_valid with bit_cnt %0h", bit_cnt);

endmodule

// ==== verilog/spi_sampler.sv ====
`timescale 1ns/1ps

module spi_sampler (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        sclk,
  input  logic                        cs_n,
  input  logic                        mosi,
  input  logic                        special_n,
  output spi_regmux_pkg::spi_sample_t sample
);

  import spi_regmux_pkg::*;

  // bit positions in the pin vector
  localparam int p_sclk    = 3;
  localparam int p_cs_n    = 2;
  localparam int p_mosi    = 1;
  localparam int p_special = 0;

  // idle bus: sclk low, cs_n high, special_n high
  localparam logic [3:0] pins_idle = 4'b0101;

  logic [3:0] pins_raw;
  logic [3:0] pins_s1;
  logic [3:0] pins_s2;
  logic [3:0] pins_prev;

  assign pins_raw = {sclk, cs_n, mosi, special_n};

  ////////////////////////////////////////
  // two-flop sync, then previous value

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pins_s1   <= pins_idle;
      pins_s2   <= pins_idle;
      pins_prev <= pins_idle;
    end
    else
    begin
      pins_s1   <= pins_raw;
      pins_s2   <= pins_s1;
      pins_prev <= pins_s2;
    end
  end

  ////////////////////////////////////////
  // edge register

  always_ff @(posedge clk)
  begin
    if (reset)
      sample <= '0;
    else
    begin
      sample.sclk_rise   <= pins_s2[p_sclk] & ~pins_prev[p_sclk];
      sample.sclk_fall   <= ~pins_s2[p_sclk] & pins_prev[p_sclk];
      // register frames open only with special_n low
      sample.frame_start <= ~pins_s2[p_cs_n] & pins_prev[p_cs_n] & ~pins_s2[p_special];
      sample.frame_end   <= pins_s2[p_cs_n] & ~pins_prev[p_cs_n];
      sample.mosi        <= pins_s2[p_mosi];
      sample.special     <= ~pins_s2[p_special];
    end
  end

  // one sclk edge per cycle at most
  assert property (@(posedge clk) disable iff (reset)
    !(sample.sclk_rise && sample.sclk_fall))
    else $error("sampler: sclk_rise and sclk_fall together");

endmodule

// ==== verilog/spi_regmux_pkg.sv ====
package spi_regmux_pkg;

  ////////////////////////////////////////
  // register map

  // high byte of a register frame
  localparam logic [7:0] addr_led     = 8'd7;
  localparam logic [7:0] addr_mux     = 8'd8;
  localparam logic [7:0] addr_dac     = 8'd9;
  localparam logic [7:0] addr_dac_rst = 8'd10;

  // only exact-length frames reach the bank
  localparam int frame_bits = 16;

  ////////////////////////////////////////
  // structs

  // one clk cycle of sampled spi pins
  typedef struct packed {
    logic sclk_rise;
    logic sclk_fall;
    logic frame_start;
    logic frame_end;
    logic mosi;
    logic special;
  } spi_sample_t;

  // addr in the high byte, value in the low byte
  typedef struct packed {
    logic [7:0] addr;
    logic [7:0] val;
  } reg_frame_t;

  typedef struct packed {
    logic [7:0] mux;
    logic [7:0] led;
    logic [2:0] dac;
    logic       dac_rst;
  } ctrl_regs_t;

  // readback word, msb goes out first
  typedef struct packed {
    logic [7:0] mux;
    logic [7:0] led;
  } reply_t;

endpackage
